// File: Makefile
TOP = sdio_cmd_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: compile.f
source/sdio_cmd_pkg.sv
source/sdio_crc7.sv
source/sdio_cmd_rx.sv
source/sdio_card_state.sv
source/sdio_io_access.sv
source/sdio_resp_tx.sv
source/sdio_cmd_top.sv
dv/sdio_cmd_sva.sv
dv/sdio_cmd_tb.sv

// File: dv/sdio_cmd_sva.sv
`timescale 1ns/1ps

module sdio_cmd_sva (
	input logic clk,
	input logic spi_reset,
	input logic cmd_oe,
	input logic rx_busy,
	input logic reg_write,
	input logic reg_read,
	input logic new_rca_req
);

	logic [6:0] oe_cycles;  // length of the current drive window

	always_ff @(posedge clk or posedge spi_reset)
	begin
		if (spi_reset)
			oe_cycles <= 7'd0;
		else if (cmd_oe)
			oe_cycles <= oe_cycles + 7'd1;
		else
			oe_cycles <= 7'd0;
	end

	// ----------------------------------------------------------
	// command line and register strobes
	// ----------------------------------------------------------
	oe_not_in_rx: assert property (@(posedge clk) disable iff (spi_reset)
		!(cmd_oe && rx_busy))
		else $error("cmd_oe driven while a command is received");

	strobes_apart: assert property (@(posedge clk) disable iff (spi_reset)
		!(reg_write && reg_read))
		else $error("reg_write and reg_read in the same cycle");

	rca_req_single: assert property (@(posedge clk) disable iff (spi_reset)
		new_rca_req |=> !new_rca_req)
		else $error("new_rca_req longer than one cycle");

	oe_not_too_long: assert property (@(posedge clk) disable iff (spi_reset)
		cmd_oe |-> (oe_cycles < 7'd48))
		else $error("response longer than 48 cycles");

	oe_full_frame: assert property (@(posedge clk) disable iff (spi_reset)
		$fell(cmd_oe) |-> (oe_cycles == 7'd48))
		else $error("response shorter than 48 cycles");

endmodule

bind sdio_cmd_top sdio_cmd_sva i_sdio_cmd_sva (
	.clk         (clk),
	.spi_reset   (spi_reset),
	.cmd_oe      (cmd_oe),
	.rx_busy     (rx_busy),
	.reg_write   (reg_write),
	.reg_read    (reg_read),
	.new_rca_req (new_rca_req)
);

// File: dv/sdio_cmd_tb.sv
`timescale 1ns/1ps

module sdio_cmd_tb
	import sdio_cmd_pkg::*;
();

	localparam int CLK_PERIOD      = 100;
	localparam int TEST_COUNT      = 6;
	localparam int CYCLES_PER_TEST = 400;
	localparam int RESP_WAIT       = 16;  // cycles from command end to cmd_oe

	localparam logic [2:0] ST_IDLE     = 3'b000;
	localparam logic [2:0] ST_INIT     = 3'b011;
	localparam logic [2:0] ST_STBY     = 3'b100;
	localparam logic [2:0] ST_CMD      = 3'b101;
	localparam logic [2:0] ST_TXFR     = 3'b110;
	localparam logic [2:0] ST_INACTIVE = 3'b111;

	logic        clk;
	logic        spi_reset;
	logic        cmd_in;
	logic        cmd_out;
	logic        cmd_oe;
	logic [15:0] rca;
	logic [23:0] ocr;
	logic [2:0]  max_num_func;
	logic [7:0]  reg_rdata = 8'h00;
	logic        dat_busy;
	logic        exec_complete;
	logic        cmd52_abort;
	logic        reg_write;
	logic        reg_read;
	logic [16:0] reg_addr;
	logic [2:0]  reg_func;
	logic [7:0]  reg_wdata;
	logic        new_rca_req;
	logic        cmd53_received;
	bus_state_t  bus_state;

	logic [7:0]  regs [256];
	int          rca_pulses   = 0;
	int          cmd53_pulses = 0;

	sdio_cmd_top #(.NCR_CYCLES (2)) i_sdio_cmd_top (
		.clk (clk), .spi_reset (spi_reset), .cmd_in (cmd_in), .cmd_out (cmd_out),
		.cmd_oe (cmd_oe), .rca (rca), .ocr (ocr), .max_num_func (max_num_func),
		.reg_rdata (reg_rdata), .dat_busy (dat_busy), .exec_complete (exec_complete),
		.cmd52_abort (cmd52_abort), .reg_write (reg_write), .reg_read (reg_read),
		.reg_addr (reg_addr), .reg_func (reg_func), .reg_wdata (reg_wdata),
		.new_rca_req (new_rca_req), .cmd53_received (cmd53_received), .bus_state (bus_state)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ----------------------------------------------------------
	// register model and pulse counters
	// ----------------------------------------------------------
	always @(negedge clk)
	begin
		if (reg_write)
			regs[reg_addr[7:0]] = reg_wdata;
		if (reg_read)
			reg_rdata = regs[reg_addr[7:0]];  // sampled at the next rising edge
		if (new_rca_req)
			rca_pulses++;
		if (cmd53_received)
			cmd53_pulses++;
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
		input string label);
		if (actual !== expected)
			stop_run($sformatf("** Error at %0t ns: %s is %0h, expected %0h",
				$time, label, actual, expected));
	endtask

	// x^7 + x^3 + 1 over the 40 leading frame bits
	function automatic logic [6:0] crc7_ref(input logic [39:0] bits);
		logic [6:0] crc;
		logic       fb;
		int         i;
		crc = 7'h00;
		for (i = 39; i >= 0; i--)
		begin
			fb  = bits[i] ^ crc[6];
			crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
		end
		return crc;
	endfunction

	function automatic logic [31:0] io_rw_arg(input logic rw, input logic [2:0] func,
		input logic raw, input logic [16:0] addr, input logic [7:0] data);
		return {rw, func, raw, 1'b0, addr, 1'b0, data};
	endfunction

	function automatic logic [31:0] io_ext_arg(input logic [2:0] func, input logic [16:0] addr);
		return {1'b0, func, 1'b0, 1'b0, addr, 9'd4};  // byte mode, 4 bytes
	endfunction

	function automatic logic [7:0] r5_flags(input logic crc_err, input logic [1:0] io_st,
		input logic fn_err);
		logic [7:0] flags;
		flags      = 8'h00;
		flags[7]   = crc_err;
		flags[5:4] = io_st;
		flags[1]   = fn_err;
		return flags;
	endfunction

	function automatic logic [31:0] r1b_status(input logic crc_err);
		logic [31:0] status;
		status       = 32'h0;
		status[23]   = crc_err;
		status[12:9] = 4'hf;
		return status;
	endfunction

	task automatic send_cmd(input logic [5:0] idx, input logic [31:0] arg, input bit bad_crc);
		logic [47:0] frame;
		logic [6:0]  crc;
		int          i;
		crc = crc7_ref({2'b01, idx, arg});
		if (bad_crc)
			crc = ~crc;
		frame = {2'b01, idx, arg, crc, 1'b1};
		repeat (2) @(negedge clk);
		for (i = 47; i >= 0; i--)
		begin
			cmd_in = frame[i];
			@(negedge clk);
		end
		cmd_in = 1'b1;
	endtask

	task automatic get_resp(output logic [47:0] frame);
		int wait_cnt;
		int i;
		wait_cnt = 0;
		while (!cmd_oe && wait_cnt < RESP_WAIT)
		begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!cmd_oe)
			stop_run("no response: cmd_oe did not rise after the command");
		for (i = 47; i >= 0; i--)
		begin
			frame[i] = cmd_out;
			if (i > 0)
				@(negedge clk);
		end
	endtask

	task automatic expect_resp(input logic [5:0] idx, input logic [31:0] arg,
		input logic [5:0] idx_field, input logic [31:0] payload, input string label);
		logic [47:0] frame;
		logic [39:0] content;
		send_cmd(idx, arg, 1'b0);
		get_resp(frame);
		content = {2'b00, idx_field, payload};
		check_eq(64'(frame), 64'({content, crc7_ref(content), 1'b1}), label);
	endtask

	task automatic expect_no_resp(input logic [5:0] idx, input logic [31:0] arg,
		input bit bad_crc);
		int i;
		send_cmd(idx, arg, bad_crc);
		for (i = 0; i < RESP_WAIT; i++)
		begin
			@(negedge clk);
			if (cmd_oe)
				stop_run($sformatf("unexpected response to CMD%0d", idx));
		end
	endtask

	// ----------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------
	task automatic test_init();
		check_eq(64'(bus_state), 64'(ST_IDLE), "bus_state after reset");
		expect_resp(CMD5, 32'h0, 6'h3f, {1'b1, max_num_func, 1'b0, 3'b000, ocr}, "R4 frame");
		check_eq(64'(bus_state), 64'(ST_INIT), "bus_state after CMD5");
		expect_resp(CMD3, 32'h0, CMD3, {rca, 16'h0000}, "R6 frame");
		check_eq(64'(rca_pulses), 64'd1, "new_rca_req pulses");
		check_eq(64'(bus_state), 64'(ST_STBY), "bus_state after CMD3");
	endtask

	task automatic test_select();
		expect_resp(CMD7, {rca, 16'h0}, CMD7, r1b_status(1'b0), "R1b select");
		check_eq(64'(bus_state), 64'(ST_CMD), "bus_state after select");
		expect_resp(CMD7, {~rca, 16'h0}, CMD7, r1b_status(1'b0), "R1b deselect");
		check_eq(64'(bus_state), 64'(ST_STBY), "bus_state after deselect");
		expect_no_resp(CMD15, 32'h0, 1'b0);
		check_eq(64'(bus_state), 64'(ST_INACTIVE), "bus_state after CMD15");
		expect_no_resp(CMD0, 32'h0, 1'b0);
		check_eq(64'(bus_state), 64'(ST_IDLE), "bus_state after CMD0");
	endtask

	task automatic test_cmd52();
		logic [16:0] addr;
		logic [7:0]  data_a;
		logic [7:0]  data_b;
		addr   = 17'($urandom);
		data_a = 8'($urandom);
		data_b = 8'($urandom);
		expect_resp(CMD5, 32'h0, 6'h3f, {1'b1, max_num_func, 1'b0, 3'b000, ocr}, "R4 again");
		expect_resp(CMD3, 32'h0, CMD3, {rca, 16'h0000}, "R6 again");
		expect_resp(CMD7, {rca, 16'h0}, CMD7, r1b_status(1'b0), "R1b reselect");
		expect_resp(CMD52, io_rw_arg(1'b1, 3'd1, 1'b0, addr, data_a), CMD52,
			{16'h0, r5_flags(1'b0, 2'd1, 1'b0), data_a}, "R5 write");
		check_eq(64'(reg_addr), 64'(addr), "reg_addr");
		check_eq(64'(reg_func), 64'd1, "reg_func");
		check_eq(64'(reg_wdata), 64'(data_a), "reg_wdata");
		// low byte differs from addr, so the model keeps both
		expect_resp(CMD52, io_rw_arg(1'b1, 3'd1, 1'b1, addr + 17'd1, data_b), CMD52,
			{16'h0, r5_flags(1'b0, 2'd1, 1'b0), data_b}, "R5 read after write");
		check_eq(64'(reg_addr), 64'(addr + 17'd1), "reg_addr raw");
		expect_resp(CMD52, io_rw_arg(1'b0, 3'd1, 1'b0, addr, 8'h00), CMD52,
			{16'h0, r5_flags(1'b0, 2'd1, 1'b0), data_a}, "R5 read");
	endtask

	task automatic test_bad_crc();
		logic [16:0] addr;
		logic [7:0]  data;
		addr = 17'($urandom);
		data = 8'($urandom);
		expect_no_resp(CMD52, io_rw_arg(1'b1, 3'd1, 1'b0, addr, ~data), 1'b1);
		check_eq(64'(bus_state), 64'(ST_CMD), "bus_state after bad crc");
		expect_resp(CMD52, io_rw_arg(1'b1, 3'd1, 1'b0, addr, data), CMD52,
			{16'h0, r5_flags(1'b1, 2'd1, 1'b0), data}, "R5 with crc flag");
		expect_resp(CMD52, io_rw_arg(1'b0, 3'd1, 1'b0, addr, 8'h00), CMD52,
			{16'h0, r5_flags(1'b0, 2'd1, 1'b0), data}, "R5 crc flag cleared");
	endtask

	task automatic test_illegal();
		expect_no_resp(CMD3, 32'h0, 1'b0);
		check_eq(64'(bus_state), 64'(ST_CMD), "bus_state after illegal CMD3");
		check_eq(64'(rca_pulses), 64'd2, "new_rca_req after illegal CMD3");
		expect_resp(CMD7, {~rca, 16'h0}, CMD7, r1b_status(1'b0), "R1b deselect");
		expect_no_resp(CMD53, io_ext_arg(3'd1, 17'($urandom)), 1'b0);
		check_eq(64'(bus_state), 64'(ST_STBY), "bus_state after illegal CMD53");
		check_eq(64'(cmd53_pulses), 64'd0, "cmd53_received in stby");
		expect_resp(CMD7, {rca, 16'h0}, CMD7, r1b_status(1'b0), "R1b select");
	endtask

	task automatic test_transfer();
		expect_resp(CMD53, io_ext_arg(3'd1, 17'($urandom)), CMD53,
			{16'h0, r5_flags(1'b0, 2'd1, 1'b0), 8'h00}, "R5 CMD53");
		check_eq(64'(cmd53_pulses), 64'd1, "cmd53_received pulses");
		check_eq(64'(bus_state), 64'(ST_TXFR), "bus_state after CMD53");
		@(negedge clk);
		exec_complete = 1'b1;
		@(negedge clk);
		exec_complete = 1'b0;
		check_eq(64'(bus_state), 64'(ST_CMD), "bus_state after exec_complete");
		expect_resp(CMD53, io_ext_arg(3'd3, 17'($urandom)), CMD53,
			{16'h0, r5_flags(1'b0, 2'd1, 1'b1), 8'h00}, "R5 function error");
		check_eq(64'(bus_state), 64'(ST_CMD), "bus_state after bad function");
		check_eq(64'(cmd53_pulses), 64'd1, "cmd53_received on bad function");
	endtask

	// watchdog
	initial
	begin
		#((TEST_COUNT * CYCLES_PER_TEST + 200) * CLK_PERIOD);
		stop_run("timeout: the tests did not finish in time");
	end

	initial
	begin
		void'($urandom(32'heb53));
		spi_reset     = 1'b1;
		cmd_in        = 1'b1;  // idle line is high
		dat_busy      = 1'b0;
		exec_complete = 1'b0;
		cmd52_abort   = 1'b0;
		max_num_func  = 3'd2;
		rca           = 16'($urandom);
		ocr           = 24'($urandom);
		for (int i = 0; i < 256; i++)
			regs[i] = 8'(i) ^ 8'hc3;
		repeat (3) @(negedge clk);
		spi_reset = 1'b0;
		test_init();
		test_select();
		test_cmd52();
		test_bad_crc();
		test_illegal();
		test_transfer();
		$display("Test passed");
		$finish;
	end

endmodule

// File: source/sdio_card_state.sv
`timescale 1ns/1ps

module sdio_card_state
	import sdio_cmd_pkg::*;
(
	input  logic                 clk,
	input  logic                 spi_reset,
	input  logic                 cmd_valid,
	input  logic [CMD_IDX_W-1:0] cmd_index,
	input  cmd_arg_u             cmd_arg,
	input  logic [15:0]          rca,
	input  logic [2:0]           max_num_func,
	input  logic                 dat_busy,
	input  logic                 exec_complete,
	input  logic                 cmd52_abort,
	output bus_state_t           bus_state,
	output logic                 resp_req,
	output logic                 func_num_err,
	output logic [1:0]           io_state,
	output logic                 new_rca_req,
	output logic                 cmd53_received,
	output logic                 cmd52_ok
);

	bus_state_t next_state;
	logic       legal;
	logic       has_resp;
	logic       fn_err;
	logic       rca_match;
	logic       is_cmd52;
	logic       is_cmd53;
	logic       cmd_ok;

	assign is_cmd52  = (cmd_index == CMD52);
	assign is_cmd53  = (cmd_index == CMD53);
	assign rca_match = (cmd_arg.rca_arg.rca == rca);
	assign fn_err    = (cmd_arg.io_rw.func > max_num_func);  // CMD53 keeps func at these bits
	assign cmd_ok    = cmd_valid && legal;
	assign cmd52_ok  = cmd_ok && is_cmd52 && !fn_err;  // starts a register access

	// ----------------------------------------------------------
	// legality and next state per command
	// ----------------------------------------------------------
	always_comb
	begin
		legal      = 1'b1;  // unknown indices pass silently
		has_resp   = 1'b0;
		next_state = bus_state;
		case (cmd_index)
			CMD0:  next_state = BUS_IDLE;
			CMD5:
			begin
				legal      = (bus_state == BUS_IDLE) || (bus_state == BUS_INIT);
				has_resp   = 1'b1;
				next_state = BUS_INIT;
			end
			CMD3:
			begin
				legal      = (bus_state == BUS_INIT) || (bus_state == BUS_STBY);
				has_resp   = 1'b1;
				next_state = BUS_STBY;
			end
			CMD7:
			begin
				legal    = (bus_state == BUS_STBY) || (bus_state == BUS_CMD);
				has_resp = 1'b1;
				if (bus_state == BUS_STBY && rca_match)
					next_state = BUS_CMD;
				else if (bus_state == BUS_CMD && !rca_match)
					next_state = BUS_STBY;  // deselected
			end
			CMD15:
			begin
				legal      = (bus_state == BUS_INIT) || (bus_state == BUS_STBY) ||
				             (bus_state == BUS_CMD);
				next_state = BUS_INACTIVE;
			end
			CMD52:
			begin
				legal    = (bus_state == BUS_CMD) || (bus_state == BUS_TXFR);
				has_resp = 1'b1;
			end
			CMD53:
			begin
				legal    = (bus_state == BUS_CMD);
				has_resp = 1'b1;
				if (!fn_err)
					next_state = BUS_TXFR;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge spi_reset)
	begin
		if (spi_reset)
		begin
			bus_state      <= BUS_IDLE;
			resp_req       <= 1'b0;
			func_num_err   <= 1'b0;
			io_state       <= 2'd0;
			new_rca_req    <= 1'b0;
			cmd53_received <= 1'b0;
		end
		else
		begin
			resp_req       <= cmd_ok && has_resp;
			new_rca_req    <= cmd_ok && (cmd_index == CMD3);
			cmd53_received <= cmd_ok && is_cmd53 && !fn_err;
			if (cmd_ok)
			begin
				bus_state <= next_state;
				if (is_cmd52 || is_cmd53)
					func_num_err <= fn_err;
			end
			else if (bus_state == BUS_TXFR && (exec_complete || cmd52_abort))
				bus_state <= BUS_CMD;

			if (bus_state == BUS_CMD || bus_state == BUS_TXFR)
				io_state <= dat_busy ? 2'd2 : 2'd1;  // 2 while dat lines busy
			else
				io_state <= 2'd0;
		end
	end

endmodule

// File: source/sdio_cmd_pkg.sv
package sdio_cmd_pkg;

	localparam int CMD_IDX_W      = 6;
	localparam int ARG_W          = 32;
	localparam int CMD_LEN        = 48;  // command and response frames alike
	localparam int RESP_CONTENT_W = 40;  // start, dir, index, payload

	// ----------------------------------------------------------
	// command indices
	// ----------------------------------------------------------
	localparam logic [CMD_IDX_W-1:0] CMD0  = 6'd0;
	localparam logic [CMD_IDX_W-1:0] CMD3  = 6'd3;
	localparam logic [CMD_IDX_W-1:0] CMD5  = 6'd5;
	localparam logic [CMD_IDX_W-1:0] CMD7  = 6'd7;
	localparam logic [CMD_IDX_W-1:0] CMD15 = 6'd15;
	localparam logic [CMD_IDX_W-1:0] CMD52 = 6'd52;
	localparam logic [CMD_IDX_W-1:0] CMD53 = 6'd53;

	// card bus states
	typedef enum logic [2:0] {
		BUS_IDLE     = 3'b000,
		BUS_INIT     = 3'b011,
		BUS_STBY     = 3'b100,
		BUS_CMD      = 3'b101,
		BUS_TXFR     = 3'b110,
		BUS_INACTIVE = 3'b111
	} bus_state_t;

	// CMD52 argument
	typedef struct packed {
		logic        rw;
		logic [2:0]  func;
		logic        raw;       // read after write
		logic        stuff_hi;
		logic [16:0] addr;
		logic        stuff_lo;
		logic [7:0]  wdata;
	} io_rw_arg_t;

	// CMD53 argument
	typedef struct packed {
		logic        rw;
		logic [2:0]  func;
		logic        block_mode;
		logic        op_code;
		logic [16:0] addr;
		logic [8:0]  count;
	} io_ext_arg_t;

	typedef struct packed {
		logic [15:0] rca;
		logic [15:0] stuff;
	} rca_arg_t;

	typedef union packed {
		io_rw_arg_t  io_rw;
		io_ext_arg_t io_ext;
		rca_arg_t    rca_arg;
	} cmd_arg_u;

endpackage

// File: source/sdio_cmd_rx.sv
`timescale 1ns/1ps

module sdio_cmd_rx
	import sdio_cmd_pkg::*;
(
	input  logic                 clk,
	input  logic                 spi_reset,
	input  logic                 cmd_in,
	input  logic                 cmd_oe,
	input  logic                 resp_done,
	output logic                 cmd_valid,
	output logic [CMD_IDX_W-1:0] cmd_index,
	output cmd_arg_u             cmd_arg,
	output logic                 crc_bad,
	output logic                 rx_busy
);

	localparam int SHIFT_W   = CMD_IDX_W + ARG_W + 1;  // dir bit, index, argument
	localparam int CRC_FIRST = SHIFT_W + 1;
	localparam int END_BIT   = CMD_LEN - 1;

	logic               cmd_in_q;
	logic [5:0]         bit_cnt;   // frame position of cmd_in_q
	logic [SHIFT_W-1:0] shift_q;
	logic               crc_mis;
	logic               frame_end;
	logic               frame_ok;
	logic               frame_crc_err;
	logic               start_det;
	logic               in_header;
	logic               in_crc;
	logic               crc_dout;

	assign start_det = !rx_busy && !cmd_in_q && !cmd_oe;
	assign in_header = rx_busy && (bit_cnt < 6'(CRC_FIRST));
	assign in_crc    = rx_busy && (bit_cnt >= 6'(CRC_FIRST)) && (bit_cnt < 6'(END_BIT));

	// the start bit is a zero into a cleared register, so it is skipped
	sdio_crc7 i_crc7 (
		.clk       (clk),
		.spi_reset (spi_reset),
		.clear     (!rx_busy),
		.gen_en    (in_header),
		.out_en    (in_crc),
		.din       (cmd_in_q),
		.dout      (crc_dout)
	);

	// ----------------------------------------------------------
	// frame counter and checks
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge spi_reset)
	begin
		if (spi_reset)
		begin
			cmd_in_q      <= 1'b1;
			rx_busy       <= 1'b0;
			bit_cnt       <= 6'd0;
			crc_mis       <= 1'b0;
			frame_end     <= 1'b0;
			frame_ok      <= 1'b0;
			frame_crc_err <= 1'b0;
		end
		else
		begin
			cmd_in_q  <= cmd_in;
			frame_end <= 1'b0;
			if (start_det)
			begin
				rx_busy <= 1'b1;
				bit_cnt <= 6'd1;
				crc_mis <= 1'b0;
			end
			else if (rx_busy)
			begin
				bit_cnt <= bit_cnt + 6'd1;
				if (in_crc && (cmd_in_q != crc_dout))
					crc_mis <= 1'b1;
				if (bit_cnt == 6'(END_BIT))
				begin
					rx_busy       <= 1'b0;
					frame_end     <= 1'b1;
					frame_crc_err <= crc_mis;
					// good crc, end bit 1, host direction
					frame_ok      <= !crc_mis && cmd_in_q && shift_q[SHIFT_W-1];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_header)
			shift_q <= {shift_q[SHIFT_W-2:0], cmd_in_q};
	end

	always_ff @(posedge clk or posedge spi_reset)
	begin
		if (spi_reset)
		begin
			cmd_valid <= 1'b0;
			crc_bad   <= 1'b0;
		end
		else
		begin
			cmd_valid <= frame_end && frame_ok;
			if (frame_end && frame_crc_err)
				crc_bad <= 1'b1;
			else if (resp_done)
				crc_bad <= 1'b0;  // reported once
		end
	end

	// held until the next good frame
	always_ff @(posedge clk)
	begin
		if (frame_end && frame_ok)
		begin
			cmd_index <= shift_q[SHIFT_W-2 -: CMD_IDX_W];
			cmd_arg   <= shift_q[ARG_W-1:0];
		end
	end

endmodule

// File: source/sdio_cmd_top.sv
`timescale 1ns/1ps

module sdio_cmd_top
	import sdio_cmd_pkg::*;
#(
	parameter int NCR_CYCLES = 2
)
(
	input  logic        clk,
	input  logic        spi_reset,
	input  logic        cmd_in,
	output logic        cmd_out,
	output logic        cmd_oe,
	input  logic [15:0] rca,
	input  logic [23:0] ocr,
	input  logic [2:0]  max_num_func,
	input  logic [7:0]  reg_rdata,
	input  logic        dat_busy,
	input  logic        exec_complete,
	input  logic        cmd52_abort,
	output logic        reg_write,
	output logic        reg_read,
	output logic [16:0] reg_addr,
	output logic [2:0]  reg_func,
	output logic [7:0]  reg_wdata,
	output logic        new_rca_req,
	output logic        cmd53_received,
	output bus_state_t  bus_state
);

	logic                 cmd_valid;
	logic [CMD_IDX_W-1:0] cmd_index;
	cmd_arg_u             cmd_arg;
	logic                 crc_bad;
	logic                 rx_busy;
	logic                 resp_done;
	logic                 resp_req;
	logic                 func_num_err;
	logic [1:0]           io_state;
	logic                 cmd52_ok;
	logic [7:0]           r5_data;

	sdio_cmd_rx i_cmd_rx (
		.clk (clk), .spi_reset (spi_reset), .cmd_in (cmd_in), .cmd_oe (cmd_oe),
		.resp_done (resp_done), .cmd_valid (cmd_valid), .cmd_index (cmd_index),
		.cmd_arg (cmd_arg), .crc_bad (crc_bad), .rx_busy (rx_busy)
	);

	sdio_card_state i_card_state (
		.clk (clk), .spi_reset (spi_reset), .cmd_valid (cmd_valid), .cmd_index (cmd_index),
		.cmd_arg (cmd_arg), .rca (rca), .max_num_func (max_num_func), .dat_busy (dat_busy),
		.exec_complete (exec_complete), .cmd52_abort (cmd52_abort), .bus_state (bus_state),
		.resp_req (resp_req), .func_num_err (func_num_err), .io_state (io_state),
		.new_rca_req (new_rca_req), .cmd53_received (cmd53_received), .cmd52_ok (cmd52_ok)
	);

	sdio_io_access i_io_access (
		.clk (clk), .spi_reset (spi_reset), .cmd52_ok (cmd52_ok), .cmd_arg (cmd_arg),
		.reg_rdata (reg_rdata), .reg_write (reg_write), .reg_read (reg_read),
		.reg_addr (reg_addr), .reg_func (reg_func), .reg_wdata (reg_wdata), .r5_data (r5_data)
	);

	sdio_resp_tx #(.NCR_CYCLES (NCR_CYCLES)) i_resp_tx (
		.clk (clk), .spi_reset (spi_reset), .resp_req (resp_req), .cmd_index (cmd_index),
		.cmd_arg (cmd_arg), .func_num_err (func_num_err), .io_state (io_state),
		.crc_bad (crc_bad), .r5_data (r5_data), .rca (rca), .ocr (ocr),
		.max_num_func (max_num_func), .cmd_out (cmd_out), .cmd_oe (cmd_oe),
		.resp_done (resp_done)
	);

endmodule

// File: source/sdio_crc7.sv
`timescale 1ns/1ps

module sdio_crc7 (
	input  logic clk,
	input  logic spi_reset,
	input  logic clear,
	input  logic gen_en,
	input  logic out_en,
	input  logic din,
	output logic dout
);

	logic [6:0] crc;
	logic       fb;

	assign fb   = din ^ crc[6];
	assign dout = crc[6];  // remainder leaves msb first

	// x^7 + x^3 + 1
	always_ff @(posedge clk or posedge spi_reset)
	begin
		if (spi_reset)
			crc <= 7'h00;
		else if (clear)
			crc <= 7'h00;
		else if (gen_en)
			crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
		else if (out_en)
			crc <= {crc[5:0], 1'b0};
	end

endmodule

// File: source/sdio_io_access.sv
`timescale 1ns/1ps

module sdio_io_access
	import sdio_cmd_pkg::*;
(
	input  logic        clk,
	input  logic        spi_reset,
	input  logic        cmd52_ok,
	input  cmd_arg_u    cmd_arg,
	input  logic [7:0]  reg_rdata,
	output logic        reg_write,
	output logic        reg_read,
	output logic [16:0] reg_addr,
	output logic [2:0]  reg_func,
	output logic [7:0]  reg_wdata,
	output logic [7:0]  r5_data
);

	logic read_pend;
	logic echo_wdata;

	// ----------------------------------------------------------
	// strobes: write first, read one cycle later
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge spi_reset)
	begin
		if (spi_reset)
		begin
			reg_write <= 1'b0;
			read_pend <= 1'b0;
			reg_read  <= 1'b0;
		end
		else
		begin
			reg_write <= cmd52_ok && cmd_arg.io_rw.rw;
			read_pend <= cmd52_ok;
			reg_read  <= read_pend;  // every access reads back
		end
	end

	// address and data held for the register side
	always_ff @(posedge clk)
	begin
		if (cmd52_ok)
		begin
			reg_addr   <= cmd_arg.io_rw.addr;
			reg_func   <= cmd_arg.io_rw.func;
			reg_wdata  <= cmd_arg.io_rw.wdata;
			echo_wdata <= cmd_arg.io_rw.rw && !cmd_arg.io_rw.raw;
			r5_data    <= cmd_arg.io_rw.wdata;
		end
		else if (reg_read && !echo_wdata)
			r5_data <= reg_rdata;  // read, or write with read after write
	end

endmodule

// File: source/sdio_resp_tx.sv
`timescale 1ns/1ps

module sdio_resp_tx
	import sdio_cmd_pkg::*;
#(
	parameter int NCR_CYCLES = 2  // at least two
)
(
	input  logic                 clk,
	input  logic                 spi_reset,
	input  logic                 resp_req,
	input  logic [CMD_IDX_W-1:0] cmd_index,
	input  cmd_arg_u             cmd_arg,
	input  logic                 func_num_err,
	input  logic [1:0]           io_state,
	input  logic                 crc_bad,
	input  logic [7:0]           r5_data,
	input  logic [15:0]          rca,
	input  logic [23:0]          ocr,
	input  logic [2:0]           max_num_func,
	output logic                 cmd_out,
	output logic                 cmd_oe,
	output logic                 resp_done
);

	localparam int NCR_W   = $clog2(NCR_CYCLES) + 1;
	localparam int END_BIT = CMD_LEN - 1;

	logic [RESP_CONTENT_W-1:0] content;
	logic [31:0]               r1b_status;
	logic [7:0]                r5_flags;
	logic [7:0]                r5_field;
	logic                      pending;
	logic [NCR_W-1:0]          ncr_cnt;
	logic [5:0]                bit_cnt;  // next frame bit to drive
	logic                      start;
	logic                      drive;
	logic [5:0]                idx;
	logic                      tx_bit;
	logic                      crc_dout;

	assign r1b_status = {8'h00, crc_bad, 10'b0, 4'hf, 9'b0};
	assign r5_flags   = {crc_bad, 1'b0, io_state, 2'b00, func_num_err, 1'b0};
	// no access was made for an out-of-range function, so no data
	assign r5_field   = (cmd_index == CMD52 && cmd_arg.io_rw.func <= max_num_func) ?
	                    r5_data : 8'h00;

	// ----------------------------------------------------------
	// response content ahead of the crc
	// ----------------------------------------------------------
	always_comb
	begin
		case (cmd_index)
			CMD5:    content = {2'b00, 6'b111111, 1'b1, max_num_func, 1'b0, 3'b000, ocr};  // R4
			CMD3:    content = {2'b00, CMD3, rca, crc_bad, 15'b0};                         // R6
			CMD7:    content = {2'b00, CMD7, r1b_status};                                   // R1b
			default: content = {2'b00, cmd_index, 16'h0000, r5_flags, r5_field};            // R5
		endcase
	end

	assign start = pending && (ncr_cnt == NCR_W'(NCR_CYCLES - 1));
	assign drive = start || (cmd_oe && bit_cnt < 6'(CMD_LEN));
	assign idx   = start ? 6'd0 : bit_cnt;

	always_comb
	begin
		if (idx < 6'(RESP_CONTENT_W))
			tx_bit = content[6'(RESP_CONTENT_W - 1) - idx];
		else if (idx < 6'(END_BIT))
			tx_bit = crc_dout;
		else
			tx_bit = 1'b1;  // end bit
	end

	sdio_crc7 i_crc7 (
		.clk       (clk),
		.spi_reset (spi_reset),
		.clear     (!drive),
		.gen_en    (drive && idx < 6'(RESP_CONTENT_W)),
		.out_en    (drive && idx >= 6'(RESP_CONTENT_W) && idx < 6'(END_BIT)),
		.din       (tx_bit),
		.dout      (crc_dout)
	);

	always_ff @(posedge clk or posedge spi_reset)
	begin
		if (spi_reset)
		begin
			pending   <= 1'b0;
			ncr_cnt   <= '0;
			cmd_oe    <= 1'b0;
			cmd_out   <= 1'b1;
			bit_cnt   <= 6'd0;
			resp_done <= 1'b0;
		end
		else
		begin
			resp_done <= 1'b0;
			if (resp_req)
			begin
				pending <= 1'b1;
				ncr_cnt <= NCR_W'(1);
			end
			else if (start)
				pending <= 1'b0;
			else if (pending)
				ncr_cnt <= ncr_cnt + 1'b1;

			if (start)
			begin
				cmd_oe  <= 1'b1;
				cmd_out <= tx_bit;
				bit_cnt <= 6'd1;
			end
			else if (drive)
			begin
				cmd_out   <= tx_bit;
				bit_cnt   <= bit_cnt + 6'd1;
				resp_done <= (bit_cnt == 6'(END_BIT));
			end
			else if (cmd_oe)
			begin
				cmd_oe  <= 1'b0;  // line back to the host
				cmd_out <= 1'b1;
			end
		end
	end

endmodule
